/* cluster_peripherals.f */
hdl/cluster_periph_pkg.sv
hdl/periph_bus_if.sv
hdl/periph_demux.sv
hdl/cluster_control_unit.sv
hdl/cluster_timer.sv
hdl/event_unit.sv
hdl/cluster_peripherals.sv
sim/tb_cluster_peripherals.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_cluster_peripherals \
  -f cluster_peripherals.f --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F "*** PASSED ***" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1

/* sim/tb_cluster_peripherals.sv */
// ********************
// Table-driven testbench for cluster_peripherals with NB_CORES = 4
// Outputs are sampled on the rising edge, before that edge's register updates
// ********************
`timescale 1ns/1ps

module tb_cluster_peripherals;

  localparam int unsigned               NB_CORES  = 4;
  localparam cluster_periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000;
  localparam int unsigned               TIMEOUT   = 20;

  // Slave windows, index in address bits 11 to 10
  localparam cluster_periph_pkg::addr_t CTRL_BASE = {20'h0, cluster_periph_pkg::SLV_CTRL, 10'h0};
  localparam cluster_periph_pkg::addr_t TIM_BASE  = {20'h0, cluster_periph_pkg::SLV_TIMER, 10'h0};
  localparam cluster_periph_pkg::addr_t EU_BASE   = {20'h0, cluster_periph_pkg::SLV_EU, 10'h0};
  localparam cluster_periph_pkg::addr_t NONE_BASE = {20'h0, cluster_periph_pkg::SLV_NONE, 10'h0};

  typedef enum logic [3:0] {
    OP_WRITE, OP_READ, OP_DMA, OP_BOOT, OP_EOC, OP_FETCH,
    OP_IRQ, OP_WAIT_IRQ, OP_QUIET, OP_MARK
  } op_e;

  // addr holds the core index for OP_BOOT, wdata the name index for OP_MARK
  typedef struct packed {
    op_e                       op;
    cluster_periph_pkg::addr_t addr;
    cluster_periph_pkg::data_t wdata;
    cluster_periph_pkg::data_t exp;
  } entry_t;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     periph_req;
  cluster_periph_pkg::addr_t                periph_add;
  logic                                     periph_wen;
  cluster_periph_pkg::data_t                periph_wdata;
  logic                                     periph_gnt;
  logic                                     periph_r_valid;
  cluster_periph_pkg::data_t                periph_r_rdata;
  logic [NB_CORES-1:0]                      dma_evt;
  logic                                     eoc;
  logic [NB_CORES-1:0]                      fetch_enable;
  cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_addr;
  logic [NB_CORES-1:0]                      irq_req;

  entry_t      table_q [$];
  string       test_names [$];
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned test_errors;
  int unsigned n_tests;
  bit          timed_out;
  int unsigned seed_val;

  cluster_peripherals #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) u_cluster_peripherals (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .periph_req_i     ( periph_req     ),
    .periph_add_i     ( periph_add     ),
    .periph_wen_i     ( periph_wen     ),
    .periph_wdata_i   ( periph_wdata   ),
    .periph_gnt_o     ( periph_gnt     ),
    .periph_r_valid_o ( periph_r_valid ),
    .periph_r_rdata_o ( periph_r_rdata ),
    .dma_evt_i        ( dma_evt        ),
    .eoc_o            ( eoc            ),
    .fetch_enable_o   ( fetch_enable   ),
    .boot_addr_o      ( boot_addr      ),
    .irq_req_o        ( irq_req        )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic cluster_periph_pkg::addr_t boot_reg(input int unsigned c);
    return CTRL_BASE + cluster_periph_pkg::addr_t'(cluster_periph_pkg::CTRL_BOOT_BASE)
           + cluster_periph_pkg::addr_t'(4 * c);
  endfunction

  function automatic cluster_periph_pkg::addr_t eu_reg(input int unsigned c, input logic [3:0] off);
    return EU_BASE + cluster_periph_pkg::addr_t'(16 * c) + cluster_periph_pkg::addr_t'(off);
  endfunction

  // ********************
  // Compare tasks
  task automatic check_data(input cluster_periph_pkg::data_t got,
                            input cluster_periph_pkg::data_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input cluster_periph_pkg::addr_t got,
                            input cluster_periph_pkg::addr_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_irq(input logic [NB_CORES-1:0] got, input logic [NB_CORES-1:0] exp,
                           input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ********************
  // Bus and event drivers
  // Called right after a rising edge, return right after one
  task automatic bus_transfer(input logic rd, input cluster_periph_pkg::addr_t addr,
                              input cluster_periph_pkg::data_t wdata,
                              output cluster_periph_pkg::data_t rdata);
    int unsigned n;
    bit          seen;
    rdata        = '0;
    periph_req   <= 1'b1;
    periph_add   <= addr;
    periph_wen   <= rd;
    periph_wdata <= wdata;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      seen = periph_gnt;
      n++;
    end
    periph_req <= 1'b0;
    if (!seen) begin
      timed_out = 1'b1;
      $display("Timeout: request to %h was not granted within %0d cycles", addr, TIMEOUT);
      return;
    end
    n    = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      seen  = periph_r_valid;
      rdata = periph_r_rdata;
      n++;
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("Timeout: no response for %h within %0d cycles", addr, TIMEOUT);
    end
  endtask

  // A write is answered with zero data
  task automatic bus_write(input cluster_periph_pkg::addr_t addr,
                           input cluster_periph_pkg::data_t data);
    cluster_periph_pkg::data_t rdata;
    bus_transfer(1'b0, addr, data, rdata);
    if (!timed_out) begin
      check_data(rdata, '0, $sformatf("write response of %h", addr));
    end
  endtask

  task automatic bus_read(input cluster_periph_pkg::addr_t addr,
                          output cluster_periph_pkg::data_t data);
    bus_transfer(1'b1, addr, '0, data);
  endtask

  task automatic dma_pulse(input logic [NB_CORES-1:0] vec);
    dma_evt <= vec;
    @(posedge clk);
    dma_evt <= '0;
  endtask

  task automatic wait_irq(input logic [NB_CORES-1:0] exp);
    int unsigned n;
    n = 0;
    while (irq_req !== exp && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    check_irq(irq_req, exp, $sformatf("irq_req_o after %0d cycles", n));
  endtask

  // No interrupt may show up while everything is idle
  task automatic quiet_irq();
    int unsigned n;
    bit          bad;
    n   = 0;
    bad = 1'b0;
    while (!bad && n < TIMEOUT) begin
      @(posedge clk);
      bad = (irq_req !== '0);
      n++;
    end
    check_irq(irq_req, '0, "irq_req_o while idle");
  endtask

  // ********************
  // Stimulus table
  task automatic add_entry(input op_e op, input cluster_periph_pkg::addr_t addr,
                           input cluster_periph_pkg::data_t wdata,
                           input cluster_periph_pkg::data_t exp);
    entry_t e;
    e.op    = op;
    e.addr  = addr;
    e.wdata = wdata;
    e.exp   = exp;
    table_q.push_back(e);
  endtask

  task automatic end_test(input string name);
    add_entry(OP_MARK, '0, cluster_periph_pkg::data_t'(test_names.size()), '0);
    test_names.push_back(name);
  endtask

  task automatic build_table();
    cluster_periph_pkg::data_t boot_vals [NB_CORES];
    cluster_periph_pkg::data_t v;
    cluster_periph_pkg::data_t all_cores;
    int unsigned               d;
    int unsigned               s;
    all_cores = cluster_periph_pkg::data_t'({NB_CORES{1'b1}});
    for (int unsigned c = 0; c < NB_CORES; c++) begin
      add_entry(OP_READ, boot_reg(c), '0, BOOT_ADDR);
      add_entry(OP_BOOT, c, '0, BOOT_ADDR);
    end
    add_entry(OP_EOC, '0, '0, '0);
    add_entry(OP_FETCH, '0, '0, '0);
    add_entry(OP_IRQ, '0, '0, '0);
    end_test("reset values");

    for (int unsigned c = 0; c < NB_CORES; c++) begin
      boot_vals[c] = $urandom;
      add_entry(OP_WRITE, boot_reg(c), boot_vals[c], '0);
      add_entry(OP_READ, boot_reg(c), '0, boot_vals[c]);
      add_entry(OP_BOOT, c, '0, boot_vals[c]);
    end
    v = $urandom;
    add_entry(OP_WRITE, CTRL_BASE + 32'h4, v, '0);
    add_entry(OP_READ, CTRL_BASE + 32'h4, '0, v & all_cores);
    add_entry(OP_FETCH, '0, '0, v & all_cores);
    add_entry(OP_WRITE, CTRL_BASE, 32'h1, '0);
    add_entry(OP_EOC, '0, '0, 32'h1);
    add_entry(OP_READ, CTRL_BASE, '0, 32'h1);
    end_test("control unit round trip");

    // Writes into the hole must not alias onto the control unit
    add_entry(OP_READ, NONE_BASE, '0, cluster_periph_pkg::UNMAPPED_RDATA);
    add_entry(OP_WRITE, NONE_BASE + 32'h40, $urandom, '0);
    add_entry(OP_WRITE, NONE_BASE, 32'h0, '0);
    add_entry(OP_READ, NONE_BASE + 32'h40, '0, cluster_periph_pkg::UNMAPPED_RDATA);
    add_entry(OP_READ, boot_reg(0), '0, boot_vals[0]);
    add_entry(OP_BOOT, 0, '0, boot_vals[0]);
    add_entry(OP_EOC, '0, '0, 32'h1);
    end_test("unmapped address");

    d = $urandom % NB_CORES;
    s = (d + 1) % NB_CORES;
    v = 32'h1 << cluster_periph_pkg::EVT_DMA;
    add_entry(OP_WRITE, eu_reg(d, cluster_periph_pkg::EU_MASK), v, '0);
    add_entry(OP_READ, eu_reg(d, cluster_periph_pkg::EU_MASK), '0, v);
    add_entry(OP_DMA, '0, 32'h1 << d, '0);
    add_entry(OP_WAIT_IRQ, '0, '0, 32'h1 << d);
    add_entry(OP_READ, eu_reg(d, cluster_periph_pkg::EU_BUFFER), '0, v);
    add_entry(OP_WRITE, eu_reg(s, cluster_periph_pkg::EU_SW_TRIG), 32'h1, '0);
    add_entry(OP_READ, eu_reg(s, cluster_periph_pkg::EU_BUFFER), '0,
              32'h1 << cluster_periph_pkg::EVT_SW);
    add_entry(OP_IRQ, '0, '0, 32'h1 << d);
    add_entry(OP_WRITE, eu_reg(d, cluster_periph_pkg::EU_BUFFER), v, '0);
    add_entry(OP_WAIT_IRQ, '0, '0, '0);
    add_entry(OP_READ, eu_reg(d, cluster_periph_pkg::EU_BUFFER), '0, '0);
    add_entry(OP_WRITE, eu_reg(s, cluster_periph_pkg::EU_BUFFER),
              32'h1 << cluster_periph_pkg::EVT_SW, '0);
    add_entry(OP_READ, eu_reg(s, cluster_periph_pkg::EU_BUFFER), '0, '0);
    end_test("event unit path");

    v = 32'h1 << cluster_periph_pkg::EVT_TIMER;
    add_entry(OP_WRITE, TIM_BASE + 32'h8, 32'd5, '0);
    add_entry(OP_READ, TIM_BASE + 32'h8, '0, 32'd5);
    for (int unsigned c = 0; c < NB_CORES; c++) begin
      add_entry(OP_WRITE, eu_reg(c, cluster_periph_pkg::EU_MASK), v, '0);
    end
    add_entry(OP_WRITE, TIM_BASE, 32'h1, '0);
    add_entry(OP_WAIT_IRQ, '0, '0, all_cores);
    for (int unsigned c = 0; c < NB_CORES; c++) begin
      add_entry(OP_READ, eu_reg(c, cluster_periph_pkg::EU_BUFFER), '0, v);
    end
    add_entry(OP_WRITE, TIM_BASE, 32'h0, '0);
    add_entry(OP_READ, TIM_BASE, '0, 32'h0);
    for (int unsigned c = 0; c < NB_CORES; c++) begin
      add_entry(OP_WRITE, eu_reg(c, cluster_periph_pkg::EU_BUFFER), v, '0);
    end
    add_entry(OP_WAIT_IRQ, '0, '0, '0);
    add_entry(OP_QUIET, '0, '0, '0);
    end_test("timer events");
  endtask

  task automatic apply_entry(input entry_t e);
    cluster_periph_pkg::data_t rdata;
    int                        idx;
    idx = int'(e.addr);
    case (e.op)
      OP_WRITE: bus_write(e.addr, e.wdata);
      OP_READ: begin
        bus_read(e.addr, rdata);
        if (!timed_out) begin
          check_data(rdata, e.exp, $sformatf("read of %h", e.addr));
        end
      end
      OP_DMA:      dma_pulse(e.wdata[NB_CORES-1:0]);
      OP_BOOT:     check_addr(boot_addr[idx], e.exp, $sformatf("boot_addr_o[%0d]", idx));
      OP_EOC:      check_data(cluster_periph_pkg::data_t'(eoc), e.exp, "eoc_o");
      OP_FETCH:    check_data(cluster_periph_pkg::data_t'(fetch_enable), e.exp, "fetch_enable_o");
      OP_IRQ:      check_irq(irq_req, e.exp[NB_CORES-1:0], "irq_req_o");
      OP_WAIT_IRQ: wait_irq(e.exp[NB_CORES-1:0]);
      OP_QUIET:    quiet_irq();
      OP_MARK: begin
        n_tests++;
        if (test_errors == 0) begin
          $display("Test %0d, %s: ok", n_tests, test_names[e.wdata]);
        end else begin
          $display("Test %0d, %s: %0d errors", n_tests, test_names[e.wdata], test_errors);
        end
        test_errors = 0;
      end
      default: ;
    endcase
  endtask

  // ********************
  // Main sequence
  initial begin
    rst_n        = 1'b0;
    periph_req   = 1'b0;
    periph_add   = '0;
    periph_wen   = 1'b0;
    periph_wdata = '0;
    dma_evt      = '0;
    n_checks     = 0;
    n_errors     = 0;
    test_errors  = 0;
    n_tests      = 0;
    timed_out    = 1'b0;
    seed_val     = $urandom(32'h30209b6d);
    build_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    foreach (table_q[i]) begin
      if (!timed_out) begin
        apply_entry(table_q[i]);
      end
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* hdl/cluster_peripherals.sv */
// ********************
// Single bus master, word accesses only; grant is combinational, response 1 cycle later
// ********************
`timescale 1ns/1ps

module cluster_peripherals #(
  parameter int unsigned               NB_CORES  = 4,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     periph_req_i,
  input  cluster_periph_pkg::addr_t                periph_add_i,
  input  logic                                     periph_wen_i,
  input  cluster_periph_pkg::data_t                periph_wdata_i,
  output logic                                     periph_gnt_o,
  output logic                                     periph_r_valid_o,
  output cluster_periph_pkg::data_t                periph_r_rdata_o,
  input  logic [NB_CORES-1:0]                      dma_evt_i,
  output logic                                     eoc_o,
  output logic [NB_CORES-1:0]                      fetch_enable_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_addr_o,
  output logic [NB_CORES-1:0]                      irq_req_o
);

  logic timer_evt;

  periph_bus_if mst_bus  ();
  periph_bus_if ctrl_bus ();
  periph_bus_if tim_bus  ();
  periph_bus_if eu_bus   ();

  // Plain ports onto the master side of the demux
  assign mst_bus.req       = periph_req_i;
  assign mst_bus.add       = periph_add_i;
  assign mst_bus.wen       = periph_wen_i;
  assign mst_bus.wdata     = periph_wdata_i;
  assign periph_gnt_o      = mst_bus.gnt;
  assign periph_r_valid_o  = mst_bus.r_valid;
  assign periph_r_rdata_o  = mst_bus.r_rdata;

  periph_demux periph_demux_i (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .mst      ( mst_bus  ),
    .slv_ctrl ( ctrl_bus ),
    .slv_tim  ( tim_bus  ),
    .slv_eu   ( eu_bus   )
  );

  cluster_control_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) cluster_control_unit_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus            ( ctrl_bus       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer cluster_timer_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .bus         ( tim_bus   ),
    .timer_evt_o ( timer_evt )
  );

  event_unit #(
    .NB_CORES ( NB_CORES )
  ) event_unit_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .bus         ( eu_bus    ),
    .timer_evt_i ( timer_evt ),
    .dma_evt_i   ( dma_evt_i ),
    .irq_req_o   ( irq_req_o )
  );

endmodule

/* hdl/event_unit.sv */
// ********************
// One 0x10 register block per core, at most 64 cores; a new event beats a clear
// ********************
`timescale 1ns/1ps

module event_unit #(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  periph_bus_if.slave         bus,
  input  logic                timer_evt_i,
  input  logic [NB_CORES-1:0] dma_evt_i,
  output logic [NB_CORES-1:0] irq_req_o
);

  logic                         wr;
  logic [3:0]                   reg_off;
  cluster_periph_pkg::evt_vec_t buffer_q [NB_CORES];
  cluster_periph_pkg::evt_vec_t mask_q   [NB_CORES];
  logic [NB_CORES-1:0]          irq_q;
  cluster_periph_pkg::data_t    rd_data;
  logic                         rvalid_q;
  cluster_periph_pkg::data_t    rdata_q;

  assign wr      = bus.req && !bus.wen;
  assign reg_off = bus.add[3:0];

  // ********************
  // Per-core event logic
  for (genvar c = 0; c < NB_CORES; c++) begin : g_core
    logic                         hit;
    cluster_periph_pkg::evt_vec_t set_v;
    cluster_periph_pkg::evt_vec_t clr_v;

    assign hit = wr && (bus.add[9:4] == 6'(c));

    always_comb begin
      set_v = '0;
      set_v[cluster_periph_pkg::EVT_TIMER] = timer_evt_i;
      set_v[cluster_periph_pkg::EVT_DMA]   = dma_evt_i[c];
      set_v[cluster_periph_pkg::EVT_SW]    = hit && (reg_off == cluster_periph_pkg::EU_SW_TRIG);
      clr_v = '0;
      if (hit && reg_off == cluster_periph_pkg::EU_BUFFER) begin
        clr_v = bus.wdata[cluster_periph_pkg::NB_EVENTS-1:0];
      end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        buffer_q[c] <= '0;
        mask_q[c]   <= '0;
        irq_q[c]    <= 1'b0;
      end else begin
        buffer_q[c] <= (buffer_q[c] & ~clr_v) | set_v;
        irq_q[c]    <= |(buffer_q[c] & mask_q[c]);
        if (hit && reg_off == cluster_periph_pkg::EU_MASK) begin
          mask_q[c] <= bus.wdata[cluster_periph_pkg::NB_EVENTS-1:0];
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      if (bus.add[9:4] == 6'(c)) begin
        if (reg_off == cluster_periph_pkg::EU_MASK) begin
          rd_data = cluster_periph_pkg::data_t'(mask_q[c]);
        end
        if (reg_off == cluster_periph_pkg::EU_BUFFER) begin
          rd_data = cluster_periph_pkg::data_t'(buffer_q[c]);
        end
      end
    end
  end

  // ********************
  // Bus response
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && bus.wen) ? rd_data : '0;
  end

  assign bus.r_valid = rvalid_q;
  assign bus.r_rdata = rdata_q;
  assign irq_req_o   = irq_q;

endmodule

/* hdl/cluster_timer.sv */
// ********************
// Counter wraps to 0 on a compare match; match pulses timer_evt_o one cycle later
// ********************
`timescale 1ns/1ps

module cluster_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  periph_bus_if.slave bus,
  output logic        timer_evt_o
);

  logic                      wr;
  logic                      match;
  logic                      en_q;
  cluster_periph_pkg::data_t count_q;
  cluster_periph_pkg::data_t cmp_q;
  logic                      evt_q;
  cluster_periph_pkg::data_t rd_data;
  logic                      rvalid_q;
  cluster_periph_pkg::data_t rdata_q;

  assign wr    = bus.req && !bus.wen;
  assign match = en_q && (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      evt_q   <= 1'b0;
    end else begin
      evt_q <= match;
      if (wr && bus.add[9:0] == cluster_periph_pkg::TIM_CFG) begin
        en_q <= bus.wdata[0];
      end
      if (wr && bus.add[9:0] == cluster_periph_pkg::TIM_CMP) begin
        cmp_q <= bus.wdata;
      end
      // A software write to the count takes priority over counting
      if (wr && bus.add[9:0] == cluster_periph_pkg::TIM_COUNT) begin
        count_q <= bus.wdata;
      end else if (en_q) begin
        count_q <= match ? '0 : count_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (bus.add[9:0])
      cluster_periph_pkg::TIM_CFG:   rd_data = cluster_periph_pkg::data_t'(en_q);
      cluster_periph_pkg::TIM_COUNT: rd_data = count_q;
      cluster_periph_pkg::TIM_CMP:   rd_data = cmp_q;
      default:                       rd_data = '0;
    endcase
  end

  // ********************
  // Bus response
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && bus.wen) ? rd_data : '0;
  end

  assign bus.r_valid = rvalid_q;
  assign bus.r_rdata = rdata_q;
  assign timer_evt_o = evt_q;

endmodule

/* hdl/cluster_control_unit.sv */
// ********************
// EOC, fetch enable and boot addresses; NB_CORES must not exceed 32
// ********************
`timescale 1ns/1ps

module cluster_control_unit #(
  parameter int unsigned               NB_CORES  = 4,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  periph_bus_if.slave                              bus,
  output logic                                     eoc_o,
  output logic [NB_CORES-1:0]                      fetch_enable_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_addr_o
);

  logic                                     wr;
  logic                                     eoc_q;
  logic [NB_CORES-1:0]                      fetch_en_q;
  cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_q;
  cluster_periph_pkg::data_t                rd_data;
  logic                                     rvalid_q;
  cluster_periph_pkg::data_t                rdata_q;

  assign wr = bus.req && !bus.wen;

  // ********************
  // Register file
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      boot_q     <= {NB_CORES{BOOT_ADDR}};
    end else if (wr) begin
      if (bus.add[9:0] == cluster_periph_pkg::CTRL_EOC) begin
        eoc_q <= bus.wdata[0];
      end
      if (bus.add[9:0] == cluster_periph_pkg::CTRL_FETCH_EN) begin
        fetch_en_q <= bus.wdata[NB_CORES-1:0];
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (bus.add[9:0] == cluster_periph_pkg::CTRL_BOOT_BASE + 10'(4 * c)) begin
          boot_q[c] <= bus.wdata;
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (bus.add[9:0] == cluster_periph_pkg::CTRL_EOC) begin
      rd_data = cluster_periph_pkg::data_t'(eoc_q);
    end
    if (bus.add[9:0] == cluster_periph_pkg::CTRL_FETCH_EN) begin
      rd_data = cluster_periph_pkg::data_t'(fetch_en_q);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      if (bus.add[9:0] == cluster_periph_pkg::CTRL_BOOT_BASE + 10'(4 * c)) begin
        rd_data = boot_q[c];
      end
    end
  end

  // ********************
  // Bus response
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && bus.wen) ? rd_data : '0;
  end

  assign bus.r_valid    = rvalid_q;
  assign bus.r_rdata    = rdata_q;
  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_q;

endmodule

/* hdl/periph_demux.sv */
// ********************
// Address bits 11:10 pick the slave; slaves must answer exactly one cycle after grant
// ********************
`timescale 1ns/1ps

module periph_demux (
  input  logic         clk_i,
  input  logic         rst_n_i,
  periph_bus_if.slave  mst,
  periph_bus_if.master slv_ctrl,
  periph_bus_if.master slv_tim,
  periph_bus_if.master slv_eu
);

  logic [1:0] sel;
  logic [1:0] sel_q;
  logic       unm_valid_q;
  logic       unm_rd_q;

  assign sel = mst.add[11:10];

  // ********************
  // Request path
  // Fields are broadcast, only req is steered
  assign slv_ctrl.req   = mst.req && (sel == cluster_periph_pkg::SLV_CTRL);
  assign slv_ctrl.add   = mst.add;
  assign slv_ctrl.wen   = mst.wen;
  assign slv_ctrl.wdata = mst.wdata;

  assign slv_tim.req    = mst.req && (sel == cluster_periph_pkg::SLV_TIMER);
  assign slv_tim.add    = mst.add;
  assign slv_tim.wen    = mst.wen;
  assign slv_tim.wdata  = mst.wdata;

  assign slv_eu.req     = mst.req && (sel == cluster_periph_pkg::SLV_EU);
  assign slv_eu.add     = mst.add;
  assign slv_eu.wen     = mst.wen;
  assign slv_eu.wdata   = mst.wdata;

  always_comb begin
    case (sel)
      cluster_periph_pkg::SLV_CTRL:  mst.gnt = slv_ctrl.gnt;
      cluster_periph_pkg::SLV_TIMER: mst.gnt = slv_tim.gnt;
      cluster_periph_pkg::SLV_EU:    mst.gnt = slv_eu.gnt;
      // Unmapped hole is granted right here
      default:                       mst.gnt = mst.req;
    endcase
  end

  // ********************
  // Response path
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q       <= cluster_periph_pkg::SLV_CTRL;
      unm_valid_q <= 1'b0;
    end else begin
      unm_valid_q <= mst.req && (sel == cluster_periph_pkg::SLV_NONE);
      if (mst.req && mst.gnt) begin
        sel_q <= sel;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    unm_rd_q <= mst.wen;
  end

  always_comb begin
    case (sel_q)
      cluster_periph_pkg::SLV_CTRL: begin
        mst.r_valid = slv_ctrl.r_valid;
        mst.r_rdata = slv_ctrl.r_rdata;
      end
      cluster_periph_pkg::SLV_TIMER: begin
        mst.r_valid = slv_tim.r_valid;
        mst.r_rdata = slv_tim.r_rdata;
      end
      cluster_periph_pkg::SLV_EU: begin
        mst.r_valid = slv_eu.r_valid;
        mst.r_rdata = slv_eu.r_rdata;
      end
      default: begin
        mst.r_valid = unm_valid_q;
        mst.r_rdata = unm_rd_q ? cluster_periph_pkg::UNMAPPED_RDATA : '0;
      end
    endcase
  end

endmodule

/* hdl/periph_bus_if.sv */
// ********************
// Peripheral bus, req/gnt then one-cycle r_valid; wen is high for a read
// ********************
`timescale 1ns/1ps

interface periph_bus_if;

  logic                      req;
  logic                      gnt;
  cluster_periph_pkg::addr_t add;
  logic                      wen;
  cluster_periph_pkg::data_t wdata;
  logic                      r_valid;
  cluster_periph_pkg::data_t r_rdata;

  modport master (
    output req, add, wen, wdata,
    input  gnt, r_valid, r_rdata
  );

  modport slave (
    input  req, add, wen, wdata,
    output gnt, r_valid, r_rdata
  );

endinterface

/* hdl/cluster_periph_pkg.sv */
// ********************
// Shared bus types, slave map and register offsets of the cluster peripherals
// Full 32-bit word accesses only; the byte offsets below are word aligned
// ********************
package cluster_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  localparam int unsigned NB_EVENTS = 8;
  typedef logic [NB_EVENTS-1:0] evt_vec_t;

  // Event line positions inside evt_vec_t
  localparam int unsigned EVT_TIMER = 0;
  localparam int unsigned EVT_DMA   = 1;
  localparam int unsigned EVT_SW    = 2;

  // Slave select, taken from address bits 11 to 10
  localparam logic [1:0] SLV_CTRL  = 2'd0;
  localparam logic [1:0] SLV_TIMER = 2'd1;
  localparam logic [1:0] SLV_EU    = 2'd2;
  localparam logic [1:0] SLV_NONE  = 2'd3;

  // Control unit offsets
  localparam logic [9:0] CTRL_EOC       = 10'h000;
  localparam logic [9:0] CTRL_FETCH_EN  = 10'h004;
  localparam logic [9:0] CTRL_BOOT_BASE = 10'h040;

  // Timer offsets
  localparam logic [9:0] TIM_CFG   = 10'h000;
  localparam logic [9:0] TIM_COUNT = 10'h004;
  localparam logic [9:0] TIM_CMP   = 10'h008;

  // Event unit offsets within the 0x10 stride of one core
  localparam logic [3:0] EU_MASK    = 4'h0;
  localparam logic [3:0] EU_BUFFER  = 4'h4;
  localparam logic [3:0] EU_SW_TRIG = 4'h8;

  localparam data_t UNMAPPED_RDATA = 32'hDEAD_B33F;

endpackage
